// File: servo_pkg.sv
package servo_pkg;

	//////////////////////////////////////////////////
	// widths and counts
	//////////////////////////////////////////////////

	localparam int N_CHAN = 4;                          // servo channels
	localparam int W_IN = 18;                           // error sample width
	localparam int W_OUT = 16;                          // dac word width
	localparam int W_CHAN = $clog2(N_CHAN);             // channel tag width
	localparam int W_GAIN = 8;                          // gain factor width
	localparam int COMP_LATENCY = 3;                    // cycles in pp_compute
	localparam int W_CNT = $clog2(COMP_LATENCY + 1);    // sequencer counter width

	//////////////////////////////////////////////////
	// vector types
	//////////////////////////////////////////////////

	typedef logic signed [W_IN-1:0] sample_t;           // raw error sample
	typedef logic signed [W_OUT-1:0] dac_word_t;        // dac output word
	typedef logic [W_CHAN-1:0] chan_t;                  // channel index
	typedef logic [W_GAIN-1:0] gain_t;                  // unsigned gain
	typedef logic [W_CNT-1:0] cnt_t;                    // state cycle counter

	// channel configuration defaults
	localparam dac_word_t DEF_MAX = {1'b0, {(W_OUT-1){1'b1}}};   // largest positive word
	localparam dac_word_t DEF_MIN = {1'b1, {(W_OUT-1){1'b0}}};   // most negative word
	localparam dac_word_t DEF_INIT = '0;                          // start at zero
	localparam gain_t DEF_MULT = gain_t'(1);                      // unity gain

	//////////////////////////////////////////////////
	// bundles
	//////////////////////////////////////////////////

	typedef struct packed {
		chan_t chan;        // target channel
		sample_t data;      // error value
	} in_sample_s;

	typedef struct packed {
		dac_word_t out_max;     // upper bound
		dac_word_t out_min;     // lower bound
		dac_word_t out_init;    // value while unlocked
		gain_t gain;            // scale factor
	} chan_cfg_s;

	typedef struct packed {
		chan_t chan;        // source channel tag
		dac_word_t data;    // finished word
	} dac_out_s;

	typedef enum logic [1:0] {
		pp_idle = 2'd0,     // wait for sample
		pp_compute = 2'd1,  // pipeline settle
		pp_send = 2'd2,     // word valid downstream
		pp_done = 2'd3      // latch previous output
	} pp_state_e;

endpackage

// File: sample_router.sv
`timescale 1ns/1ps

module sample_router (
	input logic clk_in,
	input logic reset_in,
	input servo_pkg::in_sample_s sample,                    // tagged error sample
	input logic sample_valid,                               // sample strobe
	input servo_pkg::chan_cfg_s cfg,                        // front-panel config word
	input servo_pkg::chan_t cfg_chan,                       // config target channel
	input logic update_en,                                  // arms the update pulse
	input logic update,                                     // config write pulse
	output servo_pkg::sample_t ch_sample [servo_pkg::N_CHAN],
	output logic [servo_pkg::N_CHAN-1:0] ch_valid,
	output servo_pkg::chan_cfg_s ch_cfg,                    // shared by all channels
	output logic [servo_pkg::N_CHAN-1:0] ch_update
);

	logic cfg_write;    // qualified write

	assign cfg_write = update & update_en;  // only place update_en matters

	//////////////////////////////////////////////////
	// sample steering
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		for (int i = 0; i < servo_pkg::N_CHAN; i++) begin
			if (sample_valid && sample.chan == servo_pkg::chan_t'(i)) begin
				ch_sample[i] <= sample.data;    // hold until next hit
			end
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			ch_valid <= '0;
		end else begin
			for (int i = 0; i < servo_pkg::N_CHAN; i++) begin
				ch_valid[i] <= sample_valid && (sample.chan == servo_pkg::chan_t'(i));
			end
		end
	end

	//////////////////////////////////////////////////
	// config steering
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (cfg_write) begin
			ch_cfg <= cfg;      // one copy, strobe picks the channel
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			ch_update <= '0;
		end else begin
			for (int i = 0; i < servo_pkg::N_CHAN; i++) begin
				ch_update[i] <= cfg_write && (cfg_chan == servo_pkg::chan_t'(i));  // one-hot
			end
		end
	end

endmodule

// File: output_preprocessor.sv
`timescale 1ns/1ps

module output_preprocessor (
	input logic clk_in,
	input logic reset_in,
	input servo_pkg::sample_t sample,       // routed error sample
	input logic sample_valid,               // sample strobe
	input servo_pkg::chan_cfg_s cfg,        // incoming config
	input logic update,                     // load cfg strobe
	input logic lock_en,                    // lock level
	output servo_pkg::dac_word_t data,      // processed word
	output logic data_valid                 // high in pp_send
);

	servo_pkg::pp_state_e state;            // sequencer state
	servo_pkg::cnt_t cnt;                   // cycles spent in pp_compute
	servo_pkg::chan_cfg_s cfg_q;            // active configuration
	servo_pkg::dac_word_t raw;              // captured top bits of sample
	servo_pkg::dac_word_t prev;             // last emitted word

	logic signed [servo_pkg::W_OUT+servo_pkg::W_GAIN:0] prod;  // full scaled value
	logic signed [servo_pkg::W_OUT:0] sum;                      // full accumulated value
	servo_pkg::dac_word_t prod_sat;         // step 2 result
	servo_pkg::dac_word_t sum_sat;          // step 3 result
	servo_pkg::dac_word_t locked;           // step 4 result
	servo_pkg::dac_word_t upper;            // after out_max limit

	//////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////

	// gain is unsigned, so widen with a zero before the signed multiply
	assign prod = raw * $signed({1'b0, cfg_q.gain});

	assign prod_sat = (prod > servo_pkg::DEF_MAX) ? servo_pkg::DEF_MAX :
		(prod < servo_pkg::DEF_MIN) ? servo_pkg::DEF_MIN :
		prod[servo_pkg::W_OUT-1:0];                          // in range, keep low bits

	assign sum = prod_sat + prev;                            // one extra bit, no wrap

	assign sum_sat = (sum > servo_pkg::DEF_MAX) ? servo_pkg::DEF_MAX :
		(sum < servo_pkg::DEF_MIN) ? servo_pkg::DEF_MIN :
		sum[servo_pkg::W_OUT-1:0];

	assign locked = lock_en ? sum_sat : cfg_q.out_init;     // hold init while unlocked

	assign upper = ($signed(locked) > $signed(cfg_q.out_max)) ? cfg_q.out_max : locked;

	assign data = ($signed(upper) < $signed(cfg_q.out_min)) ? cfg_q.out_min : upper;

	assign data_valid = (state == servo_pkg::pp_send);

	//////////////////////////////////////////////////
	// registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (state == servo_pkg::pp_idle && sample_valid) begin
			raw <= sample[servo_pkg::W_IN-1 -: servo_pkg::W_OUT];  // drop lsbs
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			cfg_q.out_max <= servo_pkg::DEF_MAX;
			cfg_q.out_min <= servo_pkg::DEF_MIN;
			cfg_q.out_init <= servo_pkg::DEF_INIT;
			cfg_q.gain <= servo_pkg::DEF_MULT;
		end else if (update) begin
			cfg_q <= cfg;                   // synchronous load
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			prev <= '0;
		end else if (update) begin
			prev <= cfg.out_init;           // restart accumulator
		end else if (state == servo_pkg::pp_done) begin
			prev <= data;                   // word just sent
		end
	end

	//////////////////////////////////////////////////
	// sequencer
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state <= servo_pkg::pp_idle;
			cnt <= '0;
		end else begin
			case (state)
				servo_pkg::pp_idle: begin
					if (sample_valid) begin
						state <= servo_pkg::pp_compute;
						cnt <= '0;
					end
				end
				servo_pkg::pp_compute: begin
					if (cnt == servo_pkg::cnt_t'(servo_pkg::COMP_LATENCY - 1)) begin
						state <= servo_pkg::pp_send;    // latency elapsed
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				servo_pkg::pp_send: begin
					state <= servo_pkg::pp_done;        // single valid cycle
				end
				servo_pkg::pp_done: begin
					state <= servo_pkg::pp_idle;
				end
				default: begin
					state <= servo_pkg::pp_idle;
				end
			endcase
		end
	end

endmodule

// File: dac_queue.sv
`timescale 1ns/1ps

module dac_queue (
	input logic clk_in,
	input logic reset_in,
	input servo_pkg::dac_word_t ch_data [servo_pkg::N_CHAN],  // per-channel words
	input logic [servo_pkg::N_CHAN-1:0] ch_valid,              // per-channel strobes
	output servo_pkg::dac_out_s dac,                           // tagged word
	output logic dac_valid                                     // one word per strobe
);

	logic [servo_pkg::N_CHAN-1:0] pending;                 // slot holds a word
	servo_pkg::dac_word_t held [servo_pkg::N_CHAN];        // slot contents
	servo_pkg::chan_t last_chan;                           // channel served last
	servo_pkg::chan_t pick;                                // winner this cycle
	logic found;                                           // any slot pending

	//////////////////////////////////////////////////
	// round-robin pick
	//////////////////////////////////////////////////

	// scan starts one past the last served channel and wraps
	always_comb begin
		found = 1'b0;
		pick = last_chan;
		for (int off = 1; off <= servo_pkg::N_CHAN; off++) begin
			if (!found &&
				pending[(int'(last_chan) + off) % servo_pkg::N_CHAN]) begin
				found = 1'b1;
				pick = servo_pkg::chan_t'((int'(last_chan) + off) % servo_pkg::N_CHAN);
			end
		end
	end

	//////////////////////////////////////////////////
	// slots
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		for (int i = 0; i < servo_pkg::N_CHAN; i++) begin
			if (ch_valid[i]) begin
				held[i] <= ch_data[i];      // capture on strobe
			end
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			pending <= '0;
		end else begin
			for (int i = 0; i < servo_pkg::N_CHAN; i++) begin
				if (ch_valid[i]) begin
					pending[i] <= 1'b1;             // new word wins over drain
				end else if (found && pick == servo_pkg::chan_t'(i)) begin
					pending[i] <= 1'b0;             // drained this cycle
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (found) begin
			dac.chan <= pick;
			dac.data <= held[pick];
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			dac_valid <= 1'b0;
			last_chan <= servo_pkg::chan_t'(servo_pkg::N_CHAN - 1);  // first scan hits ch 0
		end else begin
			dac_valid <= found;
			if (found) begin
				last_chan <= pick;
			end
		end
	end

endmodule

// File: servo_output_top.sv
`timescale 1ns/1ps

module servo_output_top (
	input logic clk_in,
	input logic reset_in,
	input servo_pkg::in_sample_s sample,                // tagged error sample
	input logic sample_valid,
	input servo_pkg::chan_cfg_s cfg,                    // front-panel config
	input servo_pkg::chan_t cfg_chan,
	input logic update_en,
	input logic update,
	input logic [servo_pkg::N_CHAN-1:0] lock_en,        // per-channel lock level
	output servo_pkg::dac_out_s dac,
	output logic dac_valid
);

	servo_pkg::sample_t ch_sample [servo_pkg::N_CHAN];  // routed samples
	logic [servo_pkg::N_CHAN-1:0] ch_valid;
	servo_pkg::chan_cfg_s ch_cfg;                       // shared config word
	logic [servo_pkg::N_CHAN-1:0] ch_update;
	servo_pkg::dac_word_t pp_data [servo_pkg::N_CHAN];  // finished words
	logic [servo_pkg::N_CHAN-1:0] pp_valid;

	sample_router i_sample_router (
		.clk_in(clk_in),
		.reset_in(reset_in),
		.sample(sample),
		.sample_valid(sample_valid),
		.cfg(cfg),
		.cfg_chan(cfg_chan),
		.update_en(update_en),
		.update(update),
		.ch_sample(ch_sample),
		.ch_valid(ch_valid),
		.ch_cfg(ch_cfg),
		.ch_update(ch_update)
	);

	// one engine per channel
	for (genvar g = 0; g < servo_pkg::N_CHAN; g++) begin : gen_pp
		output_preprocessor i_output_preprocessor (
			.clk_in(clk_in),
			.reset_in(reset_in),
			.sample(ch_sample[g]),
			.sample_valid(ch_valid[g]),
			.cfg(ch_cfg),
			.update(ch_update[g]),
			.lock_en(lock_en[g]),
			.data(pp_data[g]),
			.data_valid(pp_valid[g])
		);
	end

	dac_queue i_dac_queue (
		.clk_in(clk_in),
		.reset_in(reset_in),
		.ch_data(pp_data),
		.ch_valid(pp_valid),
		.dac(dac),
		.dac_valid(dac_valid)
	);

endmodule

// File: servo_output_top_asserts.sv
`timescale 1ns/1ps

module servo_output_top_asserts (
	input logic clk_in,
	input logic reset_in,
	input logic dac_valid,                              // queue output strobe
	input logic [servo_pkg::N_CHAN-1:0] pp_valid,       // engine word strobes
	input logic [servo_pkg::N_CHAN-1:0] ch_valid        // routed sample strobes
);

	int fail_count = 0;                                 // failed assertion count

	//////////////////////////////////////////////////
	// dac stream
	//////////////////////////////////////////////////

	assert property (@(posedge clk_in) disable iff (reset_in) !$isunknown(dac_valid))
		else begin
			$error("dac_valid is unknown after reset");
			fail_count++;
		end

	//////////////////////////////////////////////////
	// per-channel sequencing
	//////////////////////////////////////////////////

	for (genvar g = 0; g < servo_pkg::N_CHAN; g++) begin : gen_chan
		assert property (@(posedge clk_in) disable iff (reset_in) pp_valid[g] |=> !pp_valid[g])
			else begin
				$error("pp_valid[%0d] high for more than one cycle", g);  // single send cycle
				fail_count++;
			end

		// compute, send and done keep the engine out of idle after the capture edge
		assert property (@(posedge clk_in) disable iff (reset_in)
			ch_valid[g] |=> !ch_valid[g] [*servo_pkg::COMP_LATENCY+2])
			else begin
				$error("channel %0d got a sample outside pp_idle", g);
				fail_count++;
			end
	end

endmodule

// File: servo_output_top_tb.sv
`timescale 1ns/1ps

module servo_output_top_tb;

	typedef enum logic [2:0] {step_cfg, step_lock, step_fixed, step_rand, step_burst} step_kind_e;
	typedef struct packed {
		logic [2:0] test;                           // test number
		step_kind_e kind;
		servo_pkg::chan_t chan;
		logic en;                                   // update_en for config steps
		logic [servo_pkg::N_CHAN-1:0] lock;         // lock vector for lock steps
		servo_pkg::chan_cfg_s cfg;
		servo_pkg::sample_t data;                   // fixed sample value
	} step_s;

	logic clk_in = 1'b0;
	logic reset_in;
	servo_pkg::in_sample_s sample;
	logic sample_valid;
	servo_pkg::chan_cfg_s cfg;
	servo_pkg::chan_t cfg_chan;
	logic update_en;
	logic update;
	logic [servo_pkg::N_CHAN-1:0] lock_en;
	servo_pkg::dac_out_s dac;
	logic dac_valid;

	step_s steps [$];                               // stimulus table
	servo_pkg::dac_word_t expq [servo_pkg::N_CHAN][$];  // expected words per channel
	servo_pkg::chan_cfg_s mcfg [servo_pkg::N_CHAN];     // model config
	int mprev [servo_pkg::N_CHAN];                      // model previous output
	logic [servo_pkg::N_CHAN-1:0] mlock;                // model lock levels
	servo_pkg::dac_word_t exp_w;
	logic [31:0] lcg_state = 32'd46275;
	int n_steps = 0;
	int errors = 0;
	int words = 0;
	int test_start_errors = 0;
	int assert_seen = 0;                                // checker failures already counted
	string test_names [7] = '{"", "reset and defaults", "accumulate with gain", "saturation",
		"bounds", "lock off and update_en", "concurrency"};

	servo_output_top i_servo_output_top (.*);

	bind servo_output_top servo_output_top_asserts i_servo_output_top_asserts (
		.clk_in(clk_in), .reset_in(reset_in), .dac_valid(dac_valid),
		.pp_valid(pp_valid), .ch_valid(ch_valid));

	always #50 clk_in = ~clk_in;                    // 100 ns period

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	function automatic servo_pkg::sample_t next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return servo_pkg::sample_t'(lcg_state[31:14]);  // upper bits have the longer period
	endfunction

	function automatic int saturate(int v);
		return (v > 32767) ? 32767 : (v < -32768) ? -32768 : v;  // 16-bit signed range
	endfunction

	function automatic void predict_word(int c, servo_pkg::sample_t d);
		int v;
		v = (int'(d) >>> (servo_pkg::W_IN - servo_pkg::W_OUT)) * int'(mcfg[c].gain);
		v = saturate(saturate(v) + mprev[c]);       // scale then accumulate
		if (!mlock[c]) v = int'(mcfg[c].out_init);  // unlocked channel holds init
		if (v > int'(mcfg[c].out_max)) v = int'(mcfg[c].out_max);
		if (v < int'(mcfg[c].out_min)) v = int'(mcfg[c].out_min);
		mprev[c] = v;
		expq[c].push_back(servo_pkg::dac_word_t'(v));
	endfunction

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	function automatic void add_step(int t, step_kind_e k, int c, logic en,
		logic [servo_pkg::N_CHAN-1:0] lk, servo_pkg::chan_cfg_s cf, int d);
		steps.push_back('{3'(t), k, servo_pkg::chan_t'(c), en, lk, cf, servo_pkg::sample_t'(d)});
	endfunction

	task automatic drive_sample(input int c, input servo_pkg::sample_t d);
		sample.chan = servo_pkg::chan_t'(c);
		sample.data = d;
		sample_valid = 1'b1;
		predict_word(c, d);
		@(negedge clk_in);
		sample_valid = 1'b0;                        // one-cycle strobe
	endtask

	task automatic apply_step(input step_s s);
		case (s.kind)
			step_cfg: begin
				cfg = s.cfg;
				cfg_chan = s.chan;
				update_en = s.en;
				update = 1'b1;
				if (s.en) begin
					mcfg[s.chan] = s.cfg;
					mprev[s.chan] = int'(s.cfg.out_init);  // accumulator restarts
				end
				@(negedge clk_in);
				update = 1'b0;
				update_en = 1'b0;
			end
			step_lock: begin
				lock_en = s.lock;
				mlock = s.lock;
				@(negedge clk_in);
			end
			step_fixed: drive_sample(s.chan, s.data);
			step_rand: drive_sample(s.chan, next_random());
			default: for (int c = 0; c < servo_pkg::N_CHAN; c++) drive_sample(c, next_random());
		endcase
		repeat (8) @(negedge clk_in);               // spacing and drain
	endtask

	task automatic close_test(input int t);
		int n;
		int a;
		for (int c = 0; c < servo_pkg::N_CHAN; c++) begin
			if (expq[c].size() != 0) begin
				$display("error at %0t ns: channel %0d is missing %0d word(s)", $time, c,
					expq[c].size());
				errors++;
				expq[c].delete();
			end
		end
		a = i_servo_output_top.i_servo_output_top_asserts.fail_count - assert_seen;
		if (a != 0) begin
			$display("error at %0t ns: %0d assertion failure(s) during this test", $time, a);
			errors += a;
			assert_seen += a;
		end
		n = errors - test_start_errors;
		$display("test %0d %s: %s, %0d errors", t, test_names[t], (n == 0) ? "ok" : "failed", n);
		test_start_errors = errors;
	endtask

	//////////////////////////////////////////////////
	// monitor
	//////////////////////////////////////////////////

	always @(negedge clk_in) begin
		if (!reset_in && dac_valid === 1'b1) begin
			if (expq[dac.chan].size() == 0) begin
				$display("error at %0t ns: word on channel %0d with no sample sent",
					$time, dac.chan);
				errors++;
			end else begin
				exp_w = expq[dac.chan].pop_front();
				words++;
				if (dac.data !== exp_w) begin
					$display("mismatch at %0t ns: dac.data ch %0d expected %0d got %0d", $time,
						dac.chan, exp_w, dac.data);
					errors++;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		reset_in = 1'b1;
		sample = '0;
		sample_valid = 1'b0;
		cfg = '0;
		cfg_chan = '0;
		update_en = 1'b0;
		update = 1'b0;
		lock_en = '1;
		mlock = '1;
		for (int c = 0; c < servo_pkg::N_CHAN; c++) begin
			mcfg[c] = '{32767, -32768, 0, 1};       // reset defaults with unity gain
			mprev[c] = 0;
		end
		add_step(1, step_rand, 0, 0, 4'hf, '0, 0);
		add_step(1, step_fixed, 1, 0, 4'hf, '0, -5);
		add_step(1, step_rand, 2, 0, 4'hf, '0, 0);
		add_step(1, step_rand, 3, 0, 4'hf, '0, 0);
		add_step(2, step_cfg, 0, 1, 4'hf, '{20000, -20000, 100, 3}, 0);
		add_step(2, step_fixed, 0, 0, 4'hf, '0, 400);
		add_step(2, step_fixed, 0, 0, 4'hf, '0, -1200);
		add_step(2, step_fixed, 0, 0, 4'hf, '0, 4000);
		add_step(2, step_cfg, 1, 1, 4'hf, '{32767, -32768, -50, 2}, 0);
		add_step(2, step_rand, 1, 0, 4'hf, '0, 0);
		add_step(2, step_rand, 1, 0, 4'hf, '0, 0);
		add_step(3, step_cfg, 3, 1, 4'hf, '{32767, -32768, 30000, 1}, 0);
		add_step(3, step_fixed, 3, 0, 4'hf, '0, 100000);
		add_step(3, step_fixed, 3, 0, 4'hf, '0, 100000);
		add_step(3, step_cfg, 2, 1, 4'hf, '{32767, -32768, 0, 200}, 0);
		add_step(3, step_fixed, 2, 0, 4'hf, '0, 40000);
		add_step(3, step_cfg, 2, 1, 4'hf, '{32767, -32768, -30000, 255}, 0);
		add_step(3, step_fixed, 2, 0, 4'hf, '0, -100000);
		add_step(3, step_fixed, 2, 0, 4'hf, '0, -100000);
		add_step(4, step_cfg, 1, 1, 4'hf, '{500, -700, 0, 4}, 0);
		add_step(4, step_fixed, 1, 0, 4'hf, '0, 4000);
		add_step(4, step_fixed, 1, 0, 4'hf, '0, -8000);
		add_step(4, step_rand, 1, 0, 4'hf, '0, 0);
		add_step(5, step_lock, 0, 0, 4'he, '0, 0);  // ch 0 unlocked
		add_step(5, step_rand, 0, 0, 4'he, '0, 0);
		add_step(5, step_rand, 0, 0, 4'he, '0, 0);
		add_step(5, step_cfg, 0, 0, 4'he, '{777, -777, 777, 9}, 0);  // not armed
		add_step(5, step_rand, 0, 0, 4'he, '0, 0);
		add_step(5, step_lock, 0, 0, 4'hf, '0, 0);
		add_step(5, step_rand, 0, 0, 4'hf, '0, 0);
		add_step(6, step_burst, 0, 0, 4'hf, '0, 0);
		add_step(6, step_burst, 0, 0, 4'hf, '0, 0);
		n_steps = steps.size();
		repeat (2) @(negedge clk_in);
		reset_in = 1'b0;
		repeat (4) begin
			@(negedge clk_in);
			if (dac_valid !== 1'b0) begin
				$display("mismatch at %0t ns: dac_valid expected 0 got %b", $time, dac_valid);
				errors++;
			end
		end
		for (int i = 0; i < n_steps; i++) begin
			apply_step(steps[i]);
			if (i == n_steps - 1 || steps[i+1].test != steps[i].test) close_test(steps[i].test);
		end
		$display("summary: %0d tests, %0d words checked, %0d errors", 6, words, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// watchdog allows 12 cycles per step plus margin
	initial begin
		wait (n_steps > 0);
		#((n_steps * 12 + 50) * 100);
		$display("timeout: the run did not finish in time");
		$display("Verification failed");
		$finish;
	end

endmodule

// File: servo_output_top.f
servo_pkg.sv
sample_router.sv
output_preprocessor.sv
dac_queue.sv
servo_output_top.sv
servo_output_top_asserts.sv
servo_output_top_tb.sv
